//--- compile.f
verilog/rv_core_pkg.sv
verilog/register_file.sv
verilog/instr_decoder.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mul_pipe.sv
verilog/int_core_top.sv
test/int_core_chk.sv
test/int_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the integer core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f compile.f --top-module int_core_tb \
    -o int_core_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/int_core_sim > sim.log 2>&1
cat sim.log

grep -q "^TESTS PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- test/int_core_chk.sv
// Register file and stall assertions
`timescale 1ns/1ps
`default_nettype none

module int_core_chk (
    input wire logic                               clk,
    input wire logic                               rst_n,
    input wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input wire logic [rv_core_pkg::REG_ADDR_W-1:0] dbg_addr,
    input wire logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    input wire logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    input wire logic [rv_core_pkg::XLEN-1:0]       dbg_data,
    input wire logic                               ex_we,
    input wire logic                               wb_we,
    input wire logic                               stall
);

    // x0 has no storage, every read port returns zero
    x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr == '0) |-> (rs1_data == '0))
        else $error("x0 read nonzero on rs1 port");
    x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2_addr == '0) |-> (rs2_data == '0))
        else $error("x0 read nonzero on rs2 port");
    x0_dbg: assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_addr == '0) |-> (dbg_data == '0))
        else $error("x0 read nonzero on debug port");

    // Bubble clears the MUL from Execute
    stall_once: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
        else $error("stall held for two consecutive cycles");

    // Pipeline empty right after reset release
    we_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!ex_we && !wb_we))
        else $error("write enable active in the first cycle after reset");

endmodule

`default_nettype wire

//--- test/int_core_tb.sv
// Integer core testbench
`timescale 1ns/1ps
`default_nettype none

module int_core_tb;

    localparam int N_RANDOM = 300;
    localparam int N_INSTR  = N_RANDOM + 40;         // Random stream plus directed phases

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        illegal_instr;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;

    logic [31:0] model [0:31];                       // Architectural register state
    logic [31:0] rng;
    logic [31:0] r;
    logic [31:0] last_word;                          // Word offered at previous negedge
    logic [4:0]  prev_mul_rd;
    bit          last_acc;
    bit          prev_mul;                           // MUL now sitting in Execute
    int          errors;
    int          checks;
    int          stall_count;
    int          illegal_count;
    int          base;

    int_core_top dut0 (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .illegal_instr(illegal_instr),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    bind int_core_top int_core_chk chk0 (
        .clk(clk), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .dbg_addr(dbg_addr), .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
        .dbg_data(dbg_data), .ex_we(ex_we), .wb_we(wb_we), .stall(stall)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm12, rs1, f3, rd, rv_core_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui(input logic [19:0] imm20, input logic [4:0] rd);
        return {imm20, rd, rv_core_pkg::OPC_LUI};
    endfunction

    // Legal encodings per the RV32I/M subset
    function automatic bit legal_word(input logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        if (w[6:0] == rv_core_pkg::OPC_LUI) return 1'b1;
        if (w[6:0] == rv_core_pkg::OPC_OP_IMM) begin
            if (f3 == 3'd1) return f7 == 7'h00;
            if (f3 == 3'd5) return (f7 == 7'h00) || (f7 == rv_core_pkg::FUNCT7_ALT);
            return 1'b1;
        end
        if (w[6:0] == rv_core_pkg::OPC_OP) begin
            if (f7 == 7'h00) return 1'b1;
            if (f7 == rv_core_pkg::FUNCT7_ALT) return (f3 == 3'd0) || (f3 == 3'd5);
            if (f7 == rv_core_pkg::FUNCT7_MULDIV) return f3 == 3'd0;
        end
        return 1'b0;
    endfunction

    function automatic bit mul_word(input logic [31:0] w);
        return (w[6:0] == rv_core_pkg::OPC_OP) && (w[14:12] == 3'd0)
            && (w[31:25] == rv_core_pkg::FUNCT7_MULDIV);
    endfunction

    // Does a legal word read register r
    function automatic bit reads_reg(input logic [31:0] w, input logic [4:0] r);
        bit is_op;
        is_op = (w[6:0] == rv_core_pkg::OPC_OP);
        if (!legal_word(w)) return 1'b0;
        return ((is_op || w[6:0] == rv_core_pkg::OPC_OP_IMM) && w[19:15] == r)
            || (is_op && w[24:20] == r);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return (sa < sb) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Reference result of one legal instruction
    function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] imm;
        imm = {{20{w[31]}}, w[31:20]};
        if (w[6:0] == rv_core_pkg::OPC_LUI) return {w[31:12], 12'h000};
        if (w[6:0] == rv_core_pkg::OPC_OP_IMM)
            return alu_ref(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm);
        if (w[31:25] == rv_core_pkg::FUNCT7_MULDIV) return a * b;
        return alu_ref(w[14:12], w[30], a, b);
    endfunction

    // Register pool x0..x7 keeps hazards frequent
    function automatic logic [31:0] rand_instr(input logic [31:0] r, input logic [31:0] s);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = {2'b00, r[7:5]};
        rs1 = {2'b00, r[10:8]};
        rs2 = {2'b00, r[13:11]};
        case (r[4:0])
            5'd0:    return r_type(7'h00, rs2, rs1, 3'd0, rd);   // ADD
            5'd1:    return r_type(7'h20, rs2, rs1, 3'd0, rd);   // SUB
            5'd2:    return r_type(7'h00, rs2, rs1, 3'd1, rd);   // SLL
            5'd3:    return r_type(7'h00, rs2, rs1, 3'd2, rd);   // SLT
            5'd4:    return r_type(7'h00, rs2, rs1, 3'd3, rd);   // SLTU
            5'd5:    return r_type(7'h00, rs2, rs1, 3'd4, rd);   // XOR
            5'd6:    return r_type(7'h00, rs2, rs1, 3'd5, rd);   // SRL
            5'd7:    return r_type(7'h20, rs2, rs1, 3'd5, rd);   // SRA
            5'd8:    return r_type(7'h00, rs2, rs1, 3'd6, rd);   // OR
            5'd9:    return r_type(7'h00, rs2, rs1, 3'd7, rd);   // AND
            5'd10, 5'd11, 5'd12:
                     return r_type(7'h01, rs2, rs1, 3'd0, rd);   // MUL
            5'd13:   return i_type(s[11:0], rs1, 3'd0, rd);      // ADDI
            5'd14:   return i_type(s[11:0], rs1, 3'd2, rd);      // SLTI
            5'd15:   return i_type(s[11:0], rs1, 3'd3, rd);      // SLTIU
            5'd16:   return i_type(s[11:0], rs1, 3'd4, rd);      // XORI
            5'd17:   return i_type(s[11:0], rs1, 3'd6, rd);      // ORI
            5'd18:   return i_type(s[11:0], rs1, 3'd7, rd);      // ANDI
            5'd19:   return i_type({7'h00, s[4:0]}, rs1, 3'd1, rd);
            5'd20:   return i_type({7'h00, s[4:0]}, rs1, 3'd5, rd);
            5'd21:   return i_type({7'h20, s[4:0]}, rs1, 3'd5, rd);
            5'd22, 5'd23:
                     return lui(s[19:0], rd);
            5'd24:   return {s[31:7], 7'b0000011};                // Load opcode, unsupported
            5'd25:   return r_type(7'h20, rs2, rs1, 3'd1, rd);   // Bad funct7
            default: return i_type(s[11:0], rd, 3'd0, rd);       // Self-dependent ADDI
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_model(input logic [31:0] w);
        if (legal_word(w) && w[11:7] != 5'd0)
            model[w[11:7]] = ref_result(w, model[w[19:15]], model[w[24:20]]);
    endtask

    // Holds the word until accepted, returns on the accepting edge
    task automatic send(input logic [31:0] word);
        logic ok;
        instr_valid <= 1'b1;
        instr       <= word;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = instr_ready;
            @(posedge clk);
        end
    endtask

    task automatic read_regs(input string phase);
        for (int i = 0; i < 32; i++) begin
            dbg_addr <= 5'(i);
            @(negedge clk);
            check_value(dbg_data, model[i], $sformatf("x%0d after %s", i, phase));
            @(posedge clk);
        end
    endtask

    task automatic idle_then_read(input string phase);
        instr_valid <= 1'b0;
        repeat (3) @(posedge clk);                   // Let MUL drain through Writeback
        read_regs(phase);
    endtask

    // Compares ready, illegal pulse, and tracks accepted words
    always @(negedge clk) begin
        if (rst_n) begin
            check_value(32'(instr_ready),
                        32'(!(instr_valid && prev_mul && prev_mul_rd != 5'd0
                              && reads_reg(instr, prev_mul_rd))), "instr_ready");
            check_value(32'(illegal_instr), 32'(last_acc && !legal_word(last_word)),
                        "illegal_instr");
            if (!instr_ready) stall_count++;
            if (illegal_instr) illegal_count++;
            last_acc    = instr_valid && instr_ready;
            last_word   = instr;
            prev_mul    = last_acc && mul_word(instr);
            prev_mul_rd = instr[11:7];
            if (last_acc) apply_model(instr);
        end
    end

    initial begin
        repeat (N_INSTR * 2 + 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", N_INSTR * 2 + 200);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'h0;
        dbg_addr    = 5'd0;
        rng         = 32'h500d;
        errors      = 0;
        checks      = 0;
        stall_count = 0;
        illegal_count = 0;
        last_acc    = 1'b0;
        prev_mul    = 1'b0;
        prev_mul_rd = 5'd0;
        last_word   = 32'h0;
        for (int i = 0; i < 32; i++) model[i] = 32'h0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        read_regs("reset");

        send(lui(20'h12345, 5'd1));                  // Back-to-back chain through Execute
        send(i_type(12'h678, 5'd1, 3'd0, 5'd1));
        send(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        send(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
        send(r_type(7'h00, 5'd2, 5'd3, 3'd4, 5'd3));
        send(i_type(12'h003, 5'd3, 3'd1, 5'd4));
        send(i_type({7'h20, 5'd7}, 5'd4, 3'd5, 5'd5));
        send(r_type(7'h00, 5'd1, 5'd5, 3'd2, 5'd6));
        send(r_type(7'h00, 5'd5, 5'd6, 3'd3, 5'd6));
        send(i_type(12'hf0f, 5'd6, 3'd6, 5'd6));
        send(i_type(12'h0ff, 5'd6, 3'd7, 5'd6));
        idle_then_read("ALU chain");

        base = stall_count;
        send(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd7));   // MUL
        send(r_type(7'h00, 5'd1, 5'd7, 3'd0, 5'd8));   // Uses it at once
        send(r_type(7'h01, 5'd8, 5'd8, 3'd0, 5'd9));
        send(i_type(12'h005, 5'd0, 3'd0, 5'd10));
        send(r_type(7'h00, 5'd10, 5'd9, 3'd0, 5'd11)); // MUL from Writeback
        idle_then_read("MUL use");
        check_value(32'(stall_count - base), 32'd1, "stall cycles in MUL-use phase");

        send(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd12));
        send(i_type(12'd77, 5'd0, 3'd0, 5'd12));        // Same rd, Execute wins
        send(r_type(7'h00, 5'd0, 5'd12, 3'd0, 5'd13));
        idle_then_read("write contention");

        base = illegal_count;
        send(i_type(12'h005, 5'd1, 3'd0, 5'd0));
        send(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd0));
        send(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd14));
        send(32'h0000_0000);
        send(32'hffff_ffff);
        send(r_type(7'h20, 5'd2, 5'd1, 3'd1, 5'd1));
        send(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd15));
        idle_then_read("x0 and illegal");
        check_value(32'(illegal_count - base), 32'd3, "illegal_instr pulses");

        for (int n = 0; n < N_RANDOM; n++) begin
            rng = xorshift(rng);
            r   = rng;
            rng = xorshift(rng);
            send(rand_instr(r, rng));
        end
        idle_then_read("random mix");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
// Execute stage register and ALU
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                issue,
    input  wire logic [rv_core_pkg::XLEN-1:0]        op_a,
    input  wire logic [rv_core_pkg::XLEN-1:0]        op_b,
    input  wire logic [rv_core_pkg::XLEN-1:0]        imm,
    input  wire logic                                use_imm,
    input  rv_core_pkg::alu_op_e                     alu_op,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  rd_addr,
    input  wire logic                                writes_rd,
    input  wire logic                                is_mul,
    input  wire logic                                illegal,
    output logic                                     ex_we,
    output logic      [rv_core_pkg::REG_ADDR_W-1:0]  ex_rd,
    output logic      [rv_core_pkg::XLEN-1:0]        ex_result,
    output logic                                     ex_is_mul,
    output logic      [rv_core_pkg::REG_ADDR_W-1:0]  ex_mul_rd,
    output logic      [rv_core_pkg::XLEN-1:0]        ex_mul_a,
    output logic      [rv_core_pkg::XLEN-1:0]        ex_mul_b,
    output logic                                     illegal_instr
);

    localparam int SHAMT_W = $clog2(rv_core_pkg::XLEN);

    logic                                 alu_we_q;  // Legal ALU op, rd nonzero
    logic                                 mul_q;
    logic                                 illegal_q;
    logic [rv_core_pkg::XLEN-1:0]         a_q;
    logic [rv_core_pkg::XLEN-1:0]         b_q;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rd_q;
    rv_core_pkg::alu_op_e                 alu_op_q;
    logic [SHAMT_W-1:0]                   shamt;

    // Flags go low on a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_we_q  <= 1'b0;
            mul_q     <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            alu_we_q  <= issue && writes_rd && !is_mul && !illegal && (rd_addr != '0);
            mul_q     <= issue && is_mul && !illegal;
            illegal_q <= issue && illegal;
        end
    end

    always_ff @(posedge clk) begin
        a_q      <= op_a;
        b_q      <= use_imm ? imm : op_b;             // Immediate replaces rs2
        rd_q     <= rd_addr;
        alu_op_q <= alu_op;
    end

    assign shamt = b_q[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_q)
            rv_core_pkg::ALU_ADD:    ex_result = a_q + b_q;
            rv_core_pkg::ALU_SUB:    ex_result = a_q - b_q;
            rv_core_pkg::ALU_AND:    ex_result = a_q & b_q;
            rv_core_pkg::ALU_OR:     ex_result = a_q | b_q;
            rv_core_pkg::ALU_XOR:    ex_result = a_q ^ b_q;
            rv_core_pkg::ALU_SLL:    ex_result = a_q << shamt;
            rv_core_pkg::ALU_SRL:    ex_result = a_q >> shamt;
            rv_core_pkg::ALU_SRA:    ex_result = $signed(a_q) >>> shamt;
            rv_core_pkg::ALU_SLT:    ex_result = {31'b0, $signed(a_q) < $signed(b_q)};
            rv_core_pkg::ALU_SLTU:   ex_result = {31'b0, a_q < b_q};
            rv_core_pkg::ALU_PASS_B: ex_result = b_q; // LUI
            default:                 ex_result = '0;
        endcase
    end

    assign ex_we         = alu_we_q;
    assign ex_rd         = rd_q;
    assign ex_is_mul     = mul_q;
    assign ex_mul_rd     = rd_q;                      // Same field, MUL side
    assign ex_mul_a      = a_q;
    assign ex_mul_b      = b_q;
    assign illegal_instr = illegal_q;                 // One cycle after acceptance

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
// Operand forwarding and MUL-use stall
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire logic                                instr_valid,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  wire logic                                uses_rs1,
    input  wire logic                                uses_rs2,
    input  wire logic [rv_core_pkg::XLEN-1:0]        rf_rs1_data,
    input  wire logic [rv_core_pkg::XLEN-1:0]        rf_rs2_data,
    input  wire logic                                ex_we,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  ex_rd,
    input  wire logic [rv_core_pkg::XLEN-1:0]        ex_result,
    input  wire logic                                ex_is_mul,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  ex_mul_rd,
    input  wire logic                                wb_we,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd,
    input  wire logic [rv_core_pkg::XLEN-1:0]        wb_result,
    output logic      [rv_core_pkg::XLEN-1:0]        op_a,
    output logic      [rv_core_pkg::XLEN-1:0]        op_b,
    output logic                                     stall
);

    // Newest producer first, register file last
    function automatic logic [rv_core_pkg::XLEN-1:0] fwd(
        input logic [rv_core_pkg::REG_ADDR_W-1:0] addr,
        input logic [rv_core_pkg::XLEN-1:0]       rf_data
    );
        if (addr == '0) begin
            return '0;                                // x0
        end else if (ex_we && ex_rd == addr) begin
            return ex_result;                         // ALU in Execute
        end else if (wb_we && wb_rd == addr) begin
            return wb_result;                         // MUL in Writeback
        end
        return rf_data;
    endfunction

    assign op_a = fwd(rs1_addr, rf_rs1_data);
    assign op_b = fwd(rs2_addr, rf_rs2_data);

    // MUL product not ready until Writeback, hold the consumer one cycle
    assign stall = instr_valid && ex_is_mul && (ex_mul_rd != '0)
                 && ((uses_rs1 && rs1_addr == ex_mul_rd)
                  || (uses_rs2 && rs2_addr == ex_mul_rd));

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
// RV32 instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire logic [rv_core_pkg::XLEN-1:0]        instr,
    output logic      [rv_core_pkg::REG_ADDR_W-1:0]  rs1_addr,
    output logic      [rv_core_pkg::REG_ADDR_W-1:0]  rs2_addr,
    output logic      [rv_core_pkg::REG_ADDR_W-1:0]  rd_addr,
    output logic                                     uses_rs1,
    output logic                                     uses_rs2,
    output logic      [rv_core_pkg::XLEN-1:0]        imm,
    output logic                                     use_imm,
    output rv_core_pkg::alu_op_e                     alu_op,
    output logic                                     is_mul,
    output logic                                     writes_rd,
    output logic                                     illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rd_addr  = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        alu_op   = rv_core_pkg::ALU_ADD;
        imm      = {{20{instr[31]}}, instr[31:20]};  // I-type, sign extended
        use_imm  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        is_mul   = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                if (funct7 == rv_core_pkg::FUNCT7_MULDIV) begin
                    is_mul  = (funct3 == 3'b000);         // MUL only, no MULH or DIV
                    illegal = (funct3 != 3'b000);
                end else if (funct7 == rv_core_pkg::FUNCT7_ALT) begin
                    case (funct3)
                        3'b000:  alu_op = rv_core_pkg::ALU_SUB;
                        3'b101:  alu_op = rv_core_pkg::ALU_SRA;
                        default: illegal = 1'b1;
                    endcase
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  alu_op = rv_core_pkg::ALU_ADD;
                        3'b001:  alu_op = rv_core_pkg::ALU_SLL;
                        3'b010:  alu_op = rv_core_pkg::ALU_SLT;
                        3'b011:  alu_op = rv_core_pkg::ALU_SLTU;
                        3'b100:  alu_op = rv_core_pkg::ALU_XOR;
                        3'b101:  alu_op = rv_core_pkg::ALU_SRL;
                        3'b110:  alu_op = rv_core_pkg::ALU_OR;
                        default: alu_op = rv_core_pkg::ALU_AND;
                    endcase
                end else begin
                    illegal = 1'b1;                       // Unknown funct7
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                case (funct3)
                    3'b000:  alu_op = rv_core_pkg::ALU_ADD;
                    3'b010:  alu_op = rv_core_pkg::ALU_SLT;
                    3'b011:  alu_op = rv_core_pkg::ALU_SLTU;
                    3'b100:  alu_op = rv_core_pkg::ALU_XOR;
                    3'b110:  alu_op = rv_core_pkg::ALU_OR;
                    3'b111:  alu_op = rv_core_pkg::ALU_AND;
                    3'b001: begin
                        alu_op  = rv_core_pkg::ALU_SLL;
                        illegal = (funct7 != 7'b0000000);
                    end
                    default: begin                        // SRLI or SRAI
                        alu_op  = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                        illegal = (funct7 != 7'b0000000) && (funct7 != rv_core_pkg::FUNCT7_ALT);
                    end
                endcase
            end
            rv_core_pkg::OPC_LUI: begin
                alu_op  = rv_core_pkg::ALU_PASS_B;
                imm     = {instr[31:12], 12'b0};          // U-type
                use_imm = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        // Illegal words read nothing, so they never stall
        if (illegal) begin
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
            is_mul   = 1'b0;
        end
        writes_rd = !illegal;
    end

endmodule

`default_nettype wire

//--- verilog/int_core_top.sv
// Integer register and execution core
`timescale 1ns/1ps
`default_nettype none

module int_core_top (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                instr_valid,
    input  wire logic [rv_core_pkg::XLEN-1:0]        instr,
    output logic                                     instr_ready,
    output logic                                     illegal_instr,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic      [rv_core_pkg::XLEN-1:0]        dbg_data
);

    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd, ex_mul_rd, wb_rd;
    logic [rv_core_pkg::XLEN-1:0]       imm, rf_rs1_data, rf_rs2_data, op_a, op_b;
    logic [rv_core_pkg::XLEN-1:0]       ex_result, ex_mul_a, ex_mul_b, wb_result;
    logic                               uses_rs1, uses_rs2, use_imm, is_mul, writes_rd;
    logic                               illegal, stall, issue, ex_we, ex_is_mul, wb_we;
    rv_core_pkg::alu_op_e               alu_op;

    assign instr_ready = !stall;                      // Low only in a MUL-use stall
    assign issue       = instr_valid && !stall;       // Stall slips a bubble in

    instr_decoder u_dec (
        .instr(instr), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .imm(imm), .use_imm(use_imm),
        .alu_op(alu_op), .is_mul(is_mul), .writes_rd(writes_rd), .illegal(illegal)
    );

    hazard_unit u_haz (
        .instr_valid(instr_valid), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
        .rf_rs1_data(rf_rs1_data), .rf_rs2_data(rf_rs2_data),
        .ex_we(ex_we), .ex_rd(ex_rd), .ex_result(ex_result),
        .ex_is_mul(ex_is_mul), .ex_mul_rd(ex_mul_rd),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_result(wb_result),
        .op_a(op_a), .op_b(op_b), .stall(stall)
    );

    register_file u_rf (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .dbg_addr(dbg_addr),
        .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data), .dbg_data(dbg_data),
        .ex_we(ex_we), .wb_we(wb_we), .ex_rd(ex_rd), .wb_rd(wb_rd),
        .ex_result(ex_result), .wb_result(wb_result)
    );

    execute_stage u_ex (
        .clk(clk), .rst_n(rst_n), .issue(issue), .op_a(op_a), .op_b(op_b),
        .imm(imm), .use_imm(use_imm), .alu_op(alu_op), .rd_addr(rd_addr),
        .writes_rd(writes_rd), .is_mul(is_mul), .illegal(illegal),
        .ex_we(ex_we), .ex_rd(ex_rd), .ex_result(ex_result),
        .ex_is_mul(ex_is_mul), .ex_mul_rd(ex_mul_rd),
        .ex_mul_a(ex_mul_a), .ex_mul_b(ex_mul_b), .illegal_instr(illegal_instr)
    );

    mul_pipe u_mul (
        .clk(clk), .rst_n(rst_n), .ex_is_mul(ex_is_mul), .ex_mul_rd(ex_mul_rd),
        .ex_mul_a(ex_mul_a), .ex_mul_b(ex_mul_b),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_result(wb_result)
    );

endmodule

`default_nettype wire

//--- verilog/mul_pipe.sv
// Two-stage multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_pipe (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                ex_is_mul,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  ex_mul_rd,
    input  wire logic [rv_core_pkg::XLEN-1:0]        ex_mul_a,
    input  wire logic [rv_core_pkg::XLEN-1:0]        ex_mul_b,
    output logic                                     wb_we,
    output logic      [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd,
    output logic      [rv_core_pkg::XLEN-1:0]        wb_result
);

    logic [rv_core_pkg::XLEN-1:0] prod_lo;           // Low word, sign agnostic

    assign prod_lo = ex_mul_a * ex_mul_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_is_mul && (ex_mul_rd != '0);  // x0 target drops out
        end
    end

    // Product captured at end of Execute, written at end of Writeback
    always_ff @(posedge clk) begin
        wb_rd     <= ex_mul_rd;
        wb_result <= prod_lo;
    end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
// Dual-write register file
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic      [rv_core_pkg::XLEN-1:0]        rs1_data,
    output logic      [rv_core_pkg::XLEN-1:0]        rs2_data,
    output logic      [rv_core_pkg::XLEN-1:0]        dbg_data,
    input  wire logic                                ex_we,
    input  wire logic                                wb_we,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  ex_rd,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd,
    input  wire logic [rv_core_pkg::XLEN-1:0]        ex_result,
    input  wire logic [rv_core_pkg::XLEN-1:0]        wb_result
);

    localparam int NREGS = 2 ** rv_core_pkg::REG_ADDR_W;

    logic [rv_core_pkg::XLEN-1:0] regs [1:NREGS-1];  // x0 has no storage

    // Combinational reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

    // Execute is checked first so it wins on the same address,
    // being the younger instruction
    always_ff @(posedge clk) begin
        for (int i = 1; i < NREGS; i++) begin
            if (!rst_n) begin
                regs[i] <= '0;                        // Whole file clears
            end else if (ex_we && ex_rd == i[rv_core_pkg::REG_ADDR_W-1:0]) begin
                regs[i] <= ex_result;                 // ALU result
            end else if (wb_we && wb_rd == i[rv_core_pkg::REG_ADDR_W-1:0]) begin
                regs[i] <= wb_result;                 // MUL result
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
// RV32 integer core definitions
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;                   // Data width
    localparam int REG_ADDR_W = 5;                    // 32 architectural registers

    // Major opcodes accepted by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;   // R-type register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // I-type register-immediate
    localparam logic [6:0] OPC_LUI    = 7'b0110111;   // U-type load upper immediate

    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // SUB and SRA
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B                                    // LUI passes the immediate
    } alu_op_e;

endpackage

`default_nettype wire
